//--- verilog/alu_pkg.sv
`default_nettype none

package alu_pkg;

  // Operation class, picks the unit whose result is used
  typedef enum logic [2:0] {
    CLS_ADJ    = 3'd0,
    CLS_ADDSUB = 3'd1,
    CLS_CONV   = 3'd2,
    CLS_RSVD   = 3'd3,
    CLS_LOGIC  = 3'd4,
    CLS_SHIFT  = 3'd5,
    CLS_ROTATE = 3'd6,
    CLS_MISC   = 3'd7
  } alu_class_e;

  // Bit positions inside FLAGS
  localparam int unsigned FLAG_CF = 0;
  localparam int unsigned FLAG_PF = 2;
  localparam int unsigned FLAG_AF = 4;
  localparam int unsigned FLAG_ZF = 6;
  localparam int unsigned FLAG_SF = 7;
  localparam int unsigned FLAG_IF = 9;
  localparam int unsigned FLAG_DF = 10;
  localparam int unsigned FLAG_OF = 11;

  typedef struct packed {
    logic [31:0] x;
    logic [15:0] y;
    alu_class_e  cls;
    logic [2:0]  func;
    logic        word_op;
    logic [15:0] iflags;
    logic [15:0] seg;
    logic [15:0] off;
  } alu_req_t;

  typedef struct packed {
    logic [31:0] out;
    logic [15:0] oflags;
  } alu_rsp_t;

  // Shared by the arithmetic, adjust and shift units
  typedef struct packed {
    logic [15:0] res;
    logic        cf;
    logic        af;
    logic        of;
  } unit_res_t;

endpackage

`default_nettype wire

//--- verilog/alu_addsub.sv
`default_nettype none

module alu_addsub (
  input  logic [15:0]        x,
  input  logic [15:0]        y,
  input  logic [2:0]         func,
  input  logic               word_op,
  input  logic               cfi,
  output alu_pkg::unit_res_t result
);

  logic [15:0] a;
  logic [15:0] b;
  logic        ci;
  logic        sub_op;
  logic [16:0] r17;
  logic [8:0]  r9;
  logic [4:0]  r5;
  logic        msb_a;
  logic        msb_b;
  logic        msb_r;
  logic        inc_dec;

  // Operand setup per function
  always_comb begin
    a = x;
    b = y;
    ci = 1'b0;
    sub_op = 1'b0;
    case (func)
      3'd0: ci = cfi;
      3'd2: b = 16'd1;
      3'd3: begin
        b = 16'd1;
        sub_op = 1'b1;
      end
      // NEG is computed as 0 - x
      3'd4: begin
        a = 16'd0;
        b = x;
        sub_op = 1'b1;
      end
      3'd5: begin
        ci = cfi;
        sub_op = 1'b1;
      end
      default: sub_op = (func != 3'd1);
    endcase
  end

  // Full width, byte and nibble versions give CF and AF for either size
  assign r17 = sub_op ? {1'b0, a} - {1'b0, b} - ci : {1'b0, a} + {1'b0, b} + ci;
  assign r9  = sub_op ? {1'b0, a[7:0]} - {1'b0, b[7:0]} - ci
                      : {1'b0, a[7:0]} + {1'b0, b[7:0]} + ci;
  assign r5  = sub_op ? {1'b0, a[3:0]} - {1'b0, b[3:0]} - ci
                      : {1'b0, a[3:0]} + {1'b0, b[3:0]} + ci;

  assign msb_a   = word_op ? a[15] : a[7];
  assign msb_b   = word_op ? b[15] : b[7];
  assign msb_r   = word_op ? r17[15] : r17[7];
  assign inc_dec = (func == 3'd2) || (func == 3'd3);

  assign result.res = r17[15:0];
  assign result.af  = r5[4];
  assign result.cf  = inc_dec ? cfi : (word_op ? r17[16] : r9[8]);
  assign result.of  = sub_op ? (msb_a != msb_b) && (msb_r != msb_a)
                             : (msb_a == msb_b) && (msb_r != msb_a);

  // INC and DEC step x by one and leave CF alone
  always_comb begin
    if (inc_dec && !$isunknown({x, cfi})) begin
      assert ((result.cf == cfi) && (result.res == (func[0] ? x - 16'd1 : x + 16'd1)))
        else $error("alu_addsub: INC/DEC altered CF or missed the unit step");
    end
  end

endmodule

`default_nettype wire

//--- verilog/alu_adjust.sv
`default_nettype none

module alu_adjust (
  input  logic [15:0]        x,
  input  logic [15:0]        y,
  input  logic [2:0]         func,
  input  logic               afi,
  input  logic               cfi,
  output alu_pkg::unit_res_t result
);

  logic [7:0] al;
  logic [7:0] ah;
  logic       adj;
  logic       hi_adj;
  logic [7:0] al_add;
  logic [7:0] al_sub;

  assign al     = x[7:0];
  assign ah     = x[15:8];
  assign adj    = (al[3:0] > 4'd9) || afi;
  // High adjust uses the AL value before the low correction
  assign hi_adj = (al > 8'h99) || cfi;
  assign al_add = adj ? al + 8'd6 : al;
  assign al_sub = adj ? al - 8'd6 : al;

  always_comb begin
    result.res = 16'd0;
    result.cf = 1'b0;
    result.af = 1'b0;
    result.of = 1'b0;
    case (func)
      3'd0: begin
        result.res = adj ? {ah + 8'd1, al_add & 8'h0f} : {ah, al & 8'h0f};
        result.cf = adj;
        result.af = adj;
      end
      3'd1: result.res = {8'h00, ah * 8'd10 + al};
      3'd3: begin
        result.res = adj ? {ah - 8'd1, al_sub & 8'h0f} : {ah, al & 8'h0f};
        result.cf = adj;
        result.af = adj;
      end
      3'd4: begin
        result.res = {ah, hi_adj ? al_add + 8'h60 : al_add};
        result.cf = hi_adj;
        result.af = adj;
      end
      3'd5: begin
        result.res = {ah, hi_adj ? al_sub - 8'h60 : al_sub};
        result.cf = hi_adj;
        result.af = adj;
      end
      // Pass-through keeps the incoming carries
      3'd6: begin
        result.res = {8'h00, y[7:0]};
        result.cf = cfi;
        result.af = afi;
      end
      3'd7: begin
        result.res = y;
        result.cf = cfi;
        result.af = afi;
      end
      default: result.res = 16'd0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/alu_shift_rotate.sv
`default_nettype none

module alu_shift_rotate (
  input  logic [15:0]        x,
  input  logic [15:0]        y,
  input  logic [2:0]         func,
  input  logic               word_op,
  input  logic               cfi,
  input  logic               ofi,
  output alu_pkg::unit_res_t result
);

  logic [7:0]  n;
  logic [7:0]  k17;
  logic [7:0]  k16;
  logic [7:0]  k9;
  logic [7:0]  k8;
  logic [15:0] xs;
  logic [16:0] shl_t;
  logic [16:0] shr_t;
  logic [16:0] sar_t;
  logic [16:0] v17;
  logic [8:0]  v9;
  logic [16:0] rcl17;
  logic [16:0] rcr17;
  logic [8:0]  rcl9;
  logic [8:0]  rcr9;
  logic [15:0] rol16;
  logic [15:0] ror16;
  logic [7:0]  rol8;
  logic [7:0]  ror8;
  logic [15:0] r;
  logic        c;
  logic        cnt_zero;
  logic        msb_r;
  logic        msb2_r;

  assign n   = y[7:0];
  assign k17 = n % 8'd17;
  assign k9  = n % 8'd9;
  assign k16 = {4'h0, n[3:0]};
  assign k8  = {5'h00, n[2:0]};

  // Byte shifts left run in the upper byte so CF is always bit 16
  assign shl_t = {1'b0, word_op ? x : {x[7:0], 8'h00}} << n;
  // Right shifts keep a guard bit below the LSB for CF
  assign xs    = word_op ? x : {{8{func[0] & x[7]}}, x[7:0]};
  assign shr_t = {xs, 1'b0} >> n;
  assign sar_t = $signed({xs, 1'b0}) >>> n;

  // Rotate through carry treats CF as an extra top bit
  assign v17   = {cfi, x};
  assign v9    = {cfi, x[7:0]};
  assign rcl17 = (v17 << k17) | (v17 >> (8'd17 - k17));
  assign rcr17 = (v17 >> k17) | (v17 << (8'd17 - k17));
  assign rcl9  = (v9 << k9) | (v9 >> (8'd9 - k9));
  assign rcr9  = (v9 >> k9) | (v9 << (8'd9 - k9));
  assign rol16 = (x << k16) | (x >> (8'd16 - k16));
  assign ror16 = (x >> k16) | (x << (8'd16 - k16));
  assign rol8  = (x[7:0] << k8) | (x[7:0] >> (8'd8 - k8));
  assign ror8  = (x[7:0] >> k8) | (x[7:0] << (8'd8 - k8));

  always_comb begin
    cnt_zero = (n == 8'd0);
    case (func)
      3'b001: begin
        r = word_op ? sar_t[16:1] : {8'h00, sar_t[8:1]};
        c = sar_t[0];
      end
      3'b010: begin
        r = word_op ? shr_t[16:1] : {8'h00, shr_t[8:1]};
        c = shr_t[0];
      end
      3'b100: begin
        r = word_op ? rcl17[15:0] : {8'h00, rcl9[7:0]};
        c = word_op ? rcl17[16] : rcl9[8];
        cnt_zero = word_op ? (k17 == 8'd0) : (k9 == 8'd0);
      end
      3'b101: begin
        r = word_op ? rcr17[15:0] : {8'h00, rcr9[7:0]};
        c = word_op ? rcr17[16] : rcr9[8];
        cnt_zero = word_op ? (k17 == 8'd0) : (k9 == 8'd0);
      end
      3'b110: begin
        r = word_op ? rol16 : {8'h00, rol8};
        c = r[0];
        cnt_zero = word_op ? (k16 == 8'd0) : (k8 == 8'd0);
      end
      3'b111: begin
        r = word_op ? ror16 : {8'h00, ror8};
        c = word_op ? ror16[15] : ror8[7];
        cnt_zero = word_op ? (k16 == 8'd0) : (k8 == 8'd0);
      end
      // SHL and its SAL alias
      default: begin
        r = word_op ? shl_t[15:0] : {8'h00, shl_t[15:8]};
        c = shl_t[16];
      end
    endcase
  end

  assign msb_r  = word_op ? r[15] : r[7];
  assign msb2_r = word_op ? r[14] : r[6];

  always_comb begin
    result.af = 1'b0;
    if (cnt_zero) begin
      result.res = x;
      result.cf = cfi;
      result.of = ofi;
    end else begin
      result.res = r;
      result.cf = c;
      case (func)
        3'b001:         result.of = 1'b0;
        3'b010:         result.of = word_op ? x[15] : x[7];
        3'b101, 3'b111: result.of = msb_r ^ msb2_r;
        default:        result.of = msb_r ^ c;
      endcase
    end
  end

  // A raw count of zero passes the operand and keeps CF for every function
  always_comb begin
    if (n == 8'd0 && !$isunknown({x, cfi})) begin
      assert ((result.cf == cfi) && (result.res == x))
        else $error("alu_shift_rotate: zero count changed the operand or CF");
    end
  end

endmodule

`default_nettype wire

//--- verilog/alu_misc.sv
`default_nettype none

module alu_misc (
  input  logic [15:0] x,
  input  logic [15:0] y,
  input  logic [15:0] seg,
  input  logic [15:0] off,
  input  logic [15:0] iflags,
  input  logic [2:0]  func,
  input  logic        word_op,
  output logic [19:0] addr_res,
  output logic [15:0] flags_res
);

  logic [15:0] ea;
  logic [19:0] base;
  logic [15:0] f;

  // Offset wraps at 64K before the segment is added
  assign ea   = x + y + off;
  assign base = {seg, 4'h0};

  always_comb begin
    f = iflags;
    addr_res = 20'd0;
    case (func)
      3'd0: addr_res = base + {4'h0, ea};
      3'd1: addr_res = base + {4'h0, ea + 16'd2};
      3'd2: addr_res = {4'h0, ea};
      3'd3: addr_res = {4'h0, y};
      3'd4: begin
        case (y[2:1])
          2'b11:   f[alu_pkg::FLAG_CF] = 1'b0;
          2'b10:   f[alu_pkg::FLAG_DF] = 1'b0;
          2'b01:   f[alu_pkg::FLAG_IF] = 1'b0;
          default: f[alu_pkg::FLAG_CF] = ~iflags[alu_pkg::FLAG_CF];
        endcase
        addr_res = {4'h0, f};
      end
      3'd5: begin
        case (y[2:1])
          2'b11:   f[alu_pkg::FLAG_CF] = 1'b1;
          2'b10:   f[alu_pkg::FLAG_DF] = 1'b1;
          2'b01:   f[alu_pkg::FLAG_IF] = 1'b1;
          default: f = iflags;
        endcase
        addr_res = {4'h0, f};
      end
      default: addr_res = 20'd0;
    endcase
  end

  // Byte form only touches the low flag byte
  assign flags_res = word_op ? addr_res[15:0] : {iflags[15:8], addr_res[7:0]};

endmodule

`default_nettype wire

//--- verilog/alu_core.sv
`default_nettype none

module alu_core (
  input  alu_pkg::alu_req_t req,
  output alu_pkg::alu_rsp_t rsp
);

  alu_pkg::unit_res_t add_res;
  alu_pkg::unit_res_t adj_res;
  alu_pkg::unit_res_t sr_res;
  logic [19:0] misc_addr;
  logic [15:0] misc_flags;
  logic [15:0] log_res;
  logic [31:0] conv_res;
  logic [31:0] res_out;
  logic [15:0] res_flags;
  logic        cf;
  logic        af;
  logic        of;
  logic        keep_szp;

  alu_addsub u_addsub (
    .x       (req.x[15:0]),
    .y       (req.y),
    .func    (req.func),
    .word_op (req.word_op),
    .cfi     (req.iflags[alu_pkg::FLAG_CF]),
    .result  (add_res)
  );

  alu_adjust u_adjust (
    .x      (req.x[15:0]),
    .y      (req.y),
    .func   (req.func),
    .afi    (req.iflags[alu_pkg::FLAG_AF]),
    .cfi    (req.iflags[alu_pkg::FLAG_CF]),
    .result (adj_res)
  );

  // Shift and rotate share one unit, bit 2 of func marks a rotate
  alu_shift_rotate u_shift_rotate (
    .x       (req.x[15:0]),
    .y       (req.y),
    .func    ({req.cls == alu_pkg::CLS_ROTATE, req.func[1:0]}),
    .word_op (req.word_op),
    .cfi     (req.iflags[alu_pkg::FLAG_CF]),
    .ofi     (req.iflags[alu_pkg::FLAG_OF]),
    .result  (sr_res)
  );

  alu_misc u_misc (
    .x         (req.x[15:0]),
    .y         (req.y),
    .seg       (req.seg),
    .off       (req.off),
    .iflags    (req.iflags),
    .func      (req.func),
    .word_op   (req.word_op),
    .addr_res  (misc_addr),
    .flags_res (misc_flags)
  );

  always_comb begin
    case (req.func)
      3'd0:    log_res = req.x[15:0] & req.y;
      3'd1:    log_res = req.x[15:0] | req.y;
      3'd2:    log_res = ~req.x[15:0];
      3'd3:    log_res = req.x[15:0] ^ req.y;
      3'd4:    log_res = req.x[15:0] & req.y;
      default: log_res = 16'd0;
    endcase
  end

  // CWD for func bit 0 set, CBW otherwise
  assign conv_res = req.func[0] ? {{16{req.x[15]}}, req.x[15:0]}
                                : {{24{req.x[7]}}, req.x[7:0]};

  always_comb begin
    cf = req.iflags[alu_pkg::FLAG_CF];
    af = req.iflags[alu_pkg::FLAG_AF];
    of = req.iflags[alu_pkg::FLAG_OF];
    res_out = 32'd0;
    case (req.cls)
      alu_pkg::CLS_ADJ: begin
        res_out[15:0] = adj_res.res;
        {cf, af, of} = {adj_res.cf, adj_res.af, adj_res.of};
      end
      alu_pkg::CLS_ADDSUB: begin
        res_out[15:0] = add_res.res;
        {cf, af, of} = {add_res.cf, add_res.af, add_res.of};
      end
      alu_pkg::CLS_CONV: res_out = conv_res;
      alu_pkg::CLS_RSVD: res_out = 'x;
      alu_pkg::CLS_LOGIC: begin
        res_out[15:0] = log_res;
        {cf, af, of} = 3'b000;
      end
      alu_pkg::CLS_SHIFT, alu_pkg::CLS_ROTATE: begin
        res_out[15:0] = sr_res.res;
        {cf, af, of} = {sr_res.cf, sr_res.af, sr_res.of};
      end
      default: res_out = {12'h000, misc_addr};
    endcase
  end

  assign keep_szp = (req.cls == alu_pkg::CLS_CONV) || (req.cls == alu_pkg::CLS_RSVD) ||
                    (req.cls == alu_pkg::CLS_ROTATE) ||
                    (req.cls == alu_pkg::CLS_ADJ && req.func == 3'd1);

  always_comb begin
    res_flags = req.iflags;
    if (req.cls == alu_pkg::CLS_MISC) begin
      res_flags = misc_flags;
    end else begin
      res_flags[alu_pkg::FLAG_CF] = cf;
      res_flags[alu_pkg::FLAG_AF] = af;
      res_flags[alu_pkg::FLAG_OF] = of;
      if (!keep_szp) begin
        res_flags[alu_pkg::FLAG_PF] = ~^res_out[7:0];
        res_flags[alu_pkg::FLAG_ZF] = req.word_op ? (res_out[15:0] == 16'd0)
                                                  : (res_out[7:0] == 8'd0);
        res_flags[alu_pkg::FLAG_SF] = req.word_op ? res_out[15] : res_out[7];
      end
    end
  end

  assign rsp = '{out: res_out, oflags: res_flags};

endmodule

`default_nettype wire

//--- verilog/exec_stage.sv
`default_nettype none

module exec_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  alu_pkg::alu_req_t req,
  output logic              out_valid,
  output alu_pkg::alu_rsp_t rsp
);

  alu_pkg::alu_rsp_t core_rsp;

  alu_core u_core (
    .req (req),
    .rsp (core_rsp)
  );

  // One cycle of latency, a new request may arrive every cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      rsp <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        rsp <= core_rsp;
      end
    end
  end

  a_valid_latency: assert property (@(posedge clk)
    $past(rst_n) |-> out_valid == $past(in_valid))
    else $error("exec_stage: out_valid does not follow in_valid by one cycle");

  // Reserved class results are undefined, so only its flags are checked
  a_rsp_known: assert property (@(posedge clk)
    out_valid |-> !$isunknown(rsp.oflags) &&
                  ($past(req.cls) == alu_pkg::CLS_RSVD || !$isunknown(rsp.out)))
    else $error("exec_stage: unknown bits in a valid response");

endmodule

`default_nettype wire

//--- verification/exec_checker.sv
`default_nettype none

module exec_checker (
  input logic              clk,
  input logic              rst_n,
  input logic              in_valid,
  input alu_pkg::alu_req_t req,
  input logic              out_valid,
  input alu_pkg::alu_rsp_t rsp
);

  timeunit 1ns;
  timeprecision 100ps;

  // Expected response and the bits of out that are defined for it
  typedef struct packed {
    logic [31:0]       mask;
    alu_pkg::alu_rsp_t rsp;
  } expect_t;

  expect_t exp_q[$];
  string   test_name = "reset";
  int      pending = 0;
  int      test_checks = 0;
  int      test_errors = 0;
  int      total_checks = 0;
  int      total_errors = 0;
  int      tests_done = 0;
  logic    in_reset = 1'b0;

  function automatic int as_signed(input int v, input logic word_op);
    if (word_op) begin
      return (v >= 32768) ? v - 65536 : v;
    end
    return (v >= 128) ? v - 256 : v;
  endfunction

  function automatic alu_pkg::unit_res_t addsub_model(input alu_pkg::alu_req_t r);
    alu_pkg::unit_res_t u;
    int lim;
    int a;
    int b;
    int c;
    int sum;
    int sr;
    logic sub;
    lim = r.word_op ? 65535 : 255;
    a = int'(r.x[15:0]) & lim;
    b = int'(r.y) & lim;
    c = 0;
    sub = !(r.func inside {3'd0, 3'd1, 3'd2});
    if (r.func == 3'd0 || r.func == 3'd5) begin
      c = int'(r.iflags[alu_pkg::FLAG_CF]);
    end
    if (r.func == 3'd2 || r.func == 3'd3) begin
      b = 1;
    end
    // NEG subtracts the operand from zero
    if (r.func == 3'd4) begin
      b = a;
      a = 0;
    end
    sum = sub ? a - b - c : a + b + c;
    sr = sub ? as_signed(a, r.word_op) - as_signed(b, r.word_op) - c
             : as_signed(a, r.word_op) + as_signed(b, r.word_op) + c;
    u.res = 16'(sum & lim);
    u.cf = sub ? (sum < 0) : (sum > lim);
    u.af = sub ? ((a & 15) - (b & 15) - c < 0) : ((a & 15) + (b & 15) + c > 15);
    u.of = (sr > lim / 2) || (sr < -(lim / 2) - 1);
    if (r.func == 3'd2 || r.func == 3'd3) begin
      u.cf = r.iflags[alu_pkg::FLAG_CF];
    end
    return u;
  endfunction

  function automatic alu_pkg::unit_res_t adjust_model(input alu_pkg::alu_req_t r);
    alu_pkg::unit_res_t u;
    logic [7:0] al;
    logic [7:0] ah;
    logic low;
    logic high;
    al = r.x[7:0];
    ah = r.x[15:8];
    low = ((al & 8'h0f) > 8'd9) || r.iflags[alu_pkg::FLAG_AF];
    high = (al > 8'h99) || r.iflags[alu_pkg::FLAG_CF];
    u = '0;
    case (r.func)
      3'd0, 3'd3: begin
        if (low) begin
          al = (r.func == 3'd0) ? al + 8'd6 : al - 8'd6;
          ah = (r.func == 3'd0) ? ah + 8'd1 : ah - 8'd1;
        end
        u.res = {ah, al & 8'h0f};
        u.cf = low;
        u.af = low;
      end
      3'd1: u.res = {8'h00, 8'(ah * 8'd10 + al)};
      3'd4, 3'd5: begin
        if (low) begin
          al = (r.func == 3'd4) ? al + 8'd6 : al - 8'd6;
        end
        // High correction decided on AL before the low step
        if (high) begin
          al = (r.func == 3'd4) ? al + 8'h60 : al - 8'h60;
        end
        u.res = {ah, al};
        u.cf = high;
        u.af = low;
      end
      3'd6, 3'd7: begin
        u.res = (r.func == 3'd6) ? {8'h00, r.y[7:0]} : r.y;
        u.cf = r.iflags[alu_pkg::FLAG_CF];
        u.af = r.iflags[alu_pkg::FLAG_AF];
      end
      default: u.res = 16'd0;
    endcase
    return u;
  endfunction

  // Steps one bit position at a time after the count is reduced
  function automatic alu_pkg::unit_res_t shift_model(input alu_pkg::alu_req_t r);
    alu_pkg::unit_res_t u;
    logic [15:0] v;
    logic [15:0] top;
    logic [15:0] mask;
    logic [2:0] sel;
    logic c;
    logic nc;
    int w;
    int n;
    int k;
    int i;
    w = r.word_op ? 16 : 8;
    top = r.word_op ? 16'h8000 : 16'h0080;
    mask = r.word_op ? 16'hffff : 16'h00ff;
    v = r.x[15:0] & mask;
    c = r.iflags[alu_pkg::FLAG_CF];
    n = int'(r.y[7:0]);
    sel = {r.cls == alu_pkg::CLS_ROTATE, r.func[1:0]};
    case (sel)
      3'd4, 3'd5: k = n % (w + 1);
      3'd6, 3'd7: k = n % w;
      default: k = n;
    endcase
    for (i = 0; i < k; i++) begin
      case (sel)
        3'd1: begin
          c = v[0];
          v = (v >> 1) | (v & top);
        end
        3'd2: begin
          c = v[0];
          v = v >> 1;
        end
        3'd4: begin
          nc = (v & top) != 0;
          v = ((v << 1) | {15'd0, c}) & mask;
          c = nc;
        end
        3'd5: begin
          nc = v[0];
          v = (v >> 1) | (c ? top : 16'd0);
          c = nc;
        end
        3'd6: begin
          v = ((v << 1) | {15'd0, (v & top) != 0}) & mask;
          c = v[0];
        end
        3'd7: begin
          v = (v >> 1) | (v[0] ? top : 16'd0);
          c = (v & top) != 0;
        end
        default: begin
          c = (v & top) != 0;
          v = (v << 1) & mask;
        end
      endcase
    end
    u.af = 1'b0;
    if (k == 0) begin
      u.res = r.x[15:0];
      u.cf = r.iflags[alu_pkg::FLAG_CF];
      u.of = r.iflags[alu_pkg::FLAG_OF];
    end else begin
      u.res = v;
      u.cf = c;
      case (sel)
        3'd1: u.of = 1'b0;
        3'd2: u.of = (r.x[15:0] & top) != 0;
        3'd5, 3'd7: u.of = ((v & top) != 0) ^ ((v & (top >> 1)) != 0);
        default: u.of = ((v & top) != 0) ^ c;
      endcase
    end
    return u;
  endfunction

  function automatic alu_pkg::alu_rsp_t misc_model(input alu_pkg::alu_req_t r);
    alu_pkg::alu_rsp_t m;
    logic [15:0] ea;
    logic [15:0] f;
    logic [19:0] addr;
    ea = 16'(r.x[15:0] + r.y + r.off);
    f = r.iflags;
    addr = 20'd0;
    case (r.func)
      3'd0: addr = 20'(32'(r.seg) * 32'd16 + 32'(ea));
      3'd1: addr = 20'(32'(r.seg) * 32'd16 + 32'(16'(ea + 16'd2)));
      3'd2: addr = {4'h0, ea};
      3'd3: addr = {4'h0, r.y};
      3'd4, 3'd5: begin
        case (r.y[2:1])
          2'b11: f[alu_pkg::FLAG_CF] = (r.func == 3'd5);
          2'b10: f[alu_pkg::FLAG_DF] = (r.func == 3'd5);
          2'b01: f[alu_pkg::FLAG_IF] = (r.func == 3'd5);
          default: begin
            if (r.func == 3'd4) begin
              f[alu_pkg::FLAG_CF] = !r.iflags[alu_pkg::FLAG_CF];
            end
          end
        endcase
        addr = {4'h0, f};
      end
      default: addr = 20'd0;
    endcase
    m.out = {12'h000, addr};
    m.oflags = r.word_op ? addr[15:0] : {r.iflags[15:8], addr[7:0]};
    return m;
  endfunction

  function automatic expect_t model(input alu_pkg::alu_req_t r);
    expect_t e;
    alu_pkg::unit_res_t u;
    logic [15:0] f;
    logic keep;
    f = r.iflags;
    u = {16'h0000, f[alu_pkg::FLAG_CF], f[alu_pkg::FLAG_AF], f[alu_pkg::FLAG_OF]};
    keep = 1'b0;
    e.mask = r.word_op ? 32'hffff_ffff : 32'hffff_00ff;
    e.rsp.out = 32'd0;
    case (r.cls)
      alu_pkg::CLS_ADJ: begin
        u = adjust_model(r);
        keep = (r.func == 3'd1);
        e.mask = 32'hffff_ffff;
      end
      alu_pkg::CLS_ADDSUB: u = addsub_model(r);
      alu_pkg::CLS_CONV: begin
        keep = 1'b1;
        e.mask = 32'hffff_ffff;
      end
      // Result undefined so only the flags count
      alu_pkg::CLS_RSVD: begin
        keep = 1'b1;
        e.mask = 32'd0;
      end
      alu_pkg::CLS_LOGIC: begin
        u = '0;
        case (r.func)
          3'd0, 3'd4: u.res = r.x[15:0] & r.y;
          3'd1: u.res = r.x[15:0] | r.y;
          3'd2: u.res = ~r.x[15:0];
          3'd3: u.res = r.x[15:0] ^ r.y;
          default: u.res = 16'd0;
        endcase
      end
      alu_pkg::CLS_SHIFT: u = shift_model(r);
      alu_pkg::CLS_ROTATE: begin
        u = shift_model(r);
        keep = 1'b1;
      end
      default: begin
        e.rsp = misc_model(r);
        e.mask = 32'hffff_ffff;
        return e;
      end
    endcase
    if (r.cls == alu_pkg::CLS_CONV) begin
      e.rsp.out = r.func[0] ? 32'($signed(r.x[15:0])) : 32'($signed(r.x[7:0]));
    end else begin
      e.rsp.out = {16'h0000, u.res};
    end
    f[alu_pkg::FLAG_CF] = u.cf;
    f[alu_pkg::FLAG_AF] = u.af;
    f[alu_pkg::FLAG_OF] = u.of;
    if (!keep) begin
      f[alu_pkg::FLAG_PF] = ($countones(e.rsp.out[7:0]) % 2) == 0;
      f[alu_pkg::FLAG_ZF] = r.word_op ? (e.rsp.out[15:0] == 16'd0) : (e.rsp.out[7:0] == 8'd0);
      f[alu_pkg::FLAG_SF] = r.word_op ? e.rsp.out[15] : e.rsp.out[7];
    end
    e.rsp.oflags = f;
    return e;
  endfunction

  task automatic count_error();
    test_errors++;
    total_errors++;
  endtask

  task automatic report_problem(input string what);
    $display("Test %s: %s", test_name, what);
    count_error();
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    if (exp_q.size() != 0) begin
      report_problem("requests still waiting for a response at the end of the test");
      exp_q.delete();
    end
    tests_done++;
    $display("Test %s: %0d responses checked, %0d errors", test_name, test_checks, test_errors);
  endtask

  task automatic report_counts();
    $display("Totals: %0d tests, %0d responses checked, %0d errors",
             tests_done, total_checks, total_errors);
  endtask

  // Requests are stable at the rising edge
  always @(posedge clk) begin
    in_reset = !rst_n;
    if (rst_n && in_valid) begin
      exp_q.push_back(model(req));
    end
    pending = exp_q.size();
  end

  // Registered outputs are stable at the falling edge
  always @(negedge clk) begin
    expect_t e;
    if (in_reset) begin
      if (out_valid !== 1'b0 || rsp !== '0) begin
        report_problem("out_valid or rsp not cleared during reset");
      end
    end else if (out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        report_problem("out_valid raised without an accepted request");
      end else begin
        e = exp_q.pop_front();
        test_checks++;
        total_checks++;
        if (((rsp.out & e.mask) !== (e.rsp.out & e.mask)) ||
            (rsp.oflags !== e.rsp.oflags)) begin
          $display("[ERROR] %s: expected out=%h flags=%h, actual out=%h flags=%h",
                   test_name, e.rsp.out & e.mask, e.rsp.oflags,
                   rsp.out & e.mask, rsp.oflags);
          count_error();
        end
      end
    end else if (out_valid !== 1'b0) begin
      report_problem("out_valid is unknown");
    end else if (exp_q.size() != 0) begin
      report_problem("no response one cycle after an accepted request");
      exp_q.delete();
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

//--- verification/tb_exec_stage.sv
`default_nettype none

module tb_exec_stage;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS = 6;
  localparam int REQS_PER_TEST = 200;
  localparam int MAX_CYCLES = NUM_TESTS * REQS_PER_TEST * 2 + 100;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              in_valid;
  alu_pkg::alu_req_t req;
  logic              out_valid;
  alu_pkg::alu_rsp_t rsp;
  logic [31:0]       rng_state = 32'h617b_2cfc;
  int                cycles = 0;

  exec_stage uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .req       (req),
    .out_valid (out_valid),
    .rsp       (rsp)
  );

  exec_checker u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .req       (req),
    .out_valid (out_valid),
    .rsp       (rsp)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // LCG, upper half has the better random bits
  function automatic logic [15:0] rand16();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[31:16];
  endfunction

  function automatic alu_pkg::alu_req_t make_req(input int test_id);
    alu_pkg::alu_req_t r;
    logic [15:0] pick;
    r.x = {rand16(), rand16()};
    r.y = rand16();
    r.iflags = rand16();
    r.seg = rand16();
    r.off = rand16();
    pick = rand16();
    r.func = pick[2:0];
    r.word_op = pick[3];
    pick = rand16();
    // Zero operand now and then, covers NEG of zero
    if (pick[2:0] == 3'd0) begin
      r.x[15:0] = 16'd0;
    end
    case (test_id)
      0: r.cls = alu_pkg::CLS_ADDSUB;
      1: begin
        case (pick[5:4])
          2'd2: r.cls = alu_pkg::CLS_CONV;
          2'd3: r.cls = alu_pkg::CLS_RSVD;
          default: r.cls = alu_pkg::CLS_LOGIC;
        endcase
      end
      2: r.cls = alu_pkg::CLS_SHIFT;
      3: r.cls = alu_pkg::CLS_ROTATE;
      4: r.cls = alu_pkg::CLS_ADJ;
      default: r.cls = alu_pkg::CLS_MISC;
    endcase
    // Counts around the byte and word boundaries
    if (test_id == 2 || test_id == 3) begin
      case (pick[8:6])
        3'd0: r.y[7:0] = 8'd0;
        3'd1: r.y[7:0] = 8'd8;
        3'd2: r.y[7:0] = 8'd9;
        3'd3: r.y[7:0] = 8'd16;
        3'd4: r.y[7:0] = 8'd17;
        3'd5, 3'd6: r.y[7:0] = {3'b000, pick[13:9]};
        default: begin
        end
      endcase
    end
    return r;
  endfunction

  task automatic run_test(input int test_id, input string name);
    int sent;
    logic [15:0] gap;
    sent = 0;
    u_chk.begin_test(name);
    while (sent < REQS_PER_TEST) begin
      @(negedge clk);
      gap = rand16();
      if (gap[1:0] == 2'd0) begin
        in_valid = 1'b0;
      end else begin
        in_valid = 1'b1;
        req = make_req(test_id);
        sent++;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    while (u_chk.pending != 0) begin
      @(negedge clk);
    end
    u_chk.end_test();
  endtask

  initial begin
    rst_n = 1'b0;
    in_valid = 1'b0;
    req = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    run_test(0, "addsub");
    run_test(1, "logic_conv");
    run_test(2, "shift");
    run_test(3, "rotate");
    run_test(4, "adjust");
    run_test(5, "misc");
    repeat (2) @(negedge clk);
    u_chk.report_counts();
    if (u_chk.total_errors == 0 && u_chk.tests_done == NUM_TESTS &&
        u_chk.total_checks == NUM_TESTS * REQS_PER_TEST) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
verilog/alu_pkg.sv
verilog/alu_addsub.sv
verilog/alu_adjust.sv
verilog/alu_shift_rotate.sv
verilog/alu_misc.sv
verilog/alu_core.sv
verilog/exec_stage.sv
verification/exec_checker.sv
verification/tb_exec_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_stage
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
